// File: Makefile
SIM        = verilator
TOP        = tb_hv_core
FILELIST   = sources.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = All tests passed!
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hw/hv_core.sv
`timescale 1ns/1ps
`default_nettype none

module hv_core import hv_pkg::*; #(
    parameter int DEGLITCH_CYC = 4
) (
    input  logic              i_clk,
    input  logic              i_arst_n,
    input  logic              i_spi_sclk,
    input  logic              i_spi_csb,
    input  logic              i_spi_mosi,
    output logic              o_spi_miso,
    input  logic              i_hv_vcc_uv,
    input  logic              i_hv_vcc_ov,
    input  logic              i_hv_ot,
    input  logic              i_hv_oc,
    input  logic              i_hv_desat_flt,
    input  logic              i_hv_scp_flt,
    input  logic              i_ang_dgt_pwm_wv,  // analog pwm wave
    output logic              o_dgt_ang_pwm_en,
    output logic              o_dgt_ang_fsc_en,
    output logic              o_io_pwm_l2h,
    output logic              o_intb_n,
    output logic [REG_DW-1:0] o_reg_desat_sel,
    output logic [REG_DW-1:0] o_reg_oc_sel,
    output logic [REG_DW-1:0] o_reg_drive_delay
);

// spi <-> register block
logic               rac_req;
logic               rac_wr;
logic [REG_AW-1:0]  rac_addr;
logic [REG_DW-1:0]  rac_wdata;
logic               rac_ack;
logic [REG_DW-1:0]  rac_rdata;
logic               spi_frame_err;

logic [NUM_FLT-1:0] flt_vec;
logic               normal_en;
logic               flt_any;
ctrl_state_e        ctrl_state;

spi_slv u_spi_slv (
    .i_clk           (i_clk),
    .i_arst_n        (i_arst_n),
    .i_spi_sclk      (i_spi_sclk),
    .i_spi_csb       (i_spi_csb),
    .i_spi_mosi      (i_spi_mosi),
    .o_spi_miso      (o_spi_miso),
    .o_rac_req       (rac_req),
    .o_rac_wr        (rac_wr),
    .o_rac_addr      (rac_addr),
    .o_rac_wdata     (rac_wdata),
    .i_rac_ack       (rac_ack),
    .i_rac_rdata     (rac_rdata),
    .o_spi_frame_err (spi_frame_err)
);

hv_fault_proc #(
    .DEGLITCH_CYC (DEGLITCH_CYC)
) u_hv_fault_proc (
    .i_clk          (i_clk),
    .i_arst_n       (i_arst_n),
    .i_hv_vcc_uv    (i_hv_vcc_uv),
    .i_hv_vcc_ov    (i_hv_vcc_ov),
    .i_hv_ot        (i_hv_ot),
    .i_hv_oc        (i_hv_oc),
    .i_hv_desat_flt (i_hv_desat_flt),
    .i_hv_scp_flt   (i_hv_scp_flt),
    .o_flt_vec      (flt_vec)
);

hv_reg_slv u_hv_reg_slv (
    .i_clk             (i_clk),
    .i_arst_n          (i_arst_n),
    .i_rac_req         (rac_req),
    .i_rac_wr          (rac_wr),
    .i_rac_addr        (rac_addr),
    .i_rac_wdata       (rac_wdata),
    .i_spi_frame_err   (spi_frame_err),
    .i_flt_vec         (flt_vec),
    .i_ctrl_state      (ctrl_state),
    .o_rac_ack         (rac_ack),
    .o_rac_rdata       (rac_rdata),
    .o_normal_en       (normal_en),
    .o_flt_any         (flt_any),
    .o_reg_desat_sel   (o_reg_desat_sel),
    .o_reg_oc_sel      (o_reg_oc_sel),
    .o_reg_drive_delay (o_reg_drive_delay)
);

hv_ctrl_fsm u_hv_ctrl_fsm (
    .i_clk            (i_clk),
    .i_arst_n         (i_arst_n),
    .i_normal_en      (normal_en),
    .i_flt_any        (flt_any),
    .i_ang_dgt_pwm_wv (i_ang_dgt_pwm_wv),
    .o_ctrl_state     (ctrl_state),
    .o_dgt_ang_pwm_en (o_dgt_ang_pwm_en),
    .o_dgt_ang_fsc_en (o_dgt_ang_fsc_en),
    .o_io_pwm_l2h     (o_io_pwm_l2h),
    .o_intb_n         (o_intb_n)
);

endmodule

`default_nettype wire

// File: hw/hv_ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module hv_ctrl_fsm import hv_pkg::*; (
    input  logic        i_clk,
    input  logic        i_arst_n,
    input  logic        i_normal_en,
    input  logic        i_flt_any,
    input  logic        i_ang_dgt_pwm_wv,
    output ctrl_state_e o_ctrl_state,
    output logic        o_dgt_ang_pwm_en,
    output logic        o_dgt_ang_fsc_en,
    output logic        o_io_pwm_l2h,
    output logic        o_intb_n
);

ctrl_state_e state_q;
ctrl_state_e state_d;
logic        pwm_on;

// ========================================
// state register
// ========================================
always_comb begin
    state_d = state_q;
    case (state_q)
        ST_CFG: begin
            if (i_normal_en && !i_flt_any) state_d = ST_NORMAL;
        end
        ST_NORMAL: begin
            if (i_flt_any) begin
                state_d = ST_FAULT;         // fault beats mode change
            end else if (!i_normal_en) begin
                state_d = ST_CFG;
            end
        end
        ST_FAULT: begin
            if (!i_flt_any) state_d = ST_CFG;
        end
        default: state_d = ST_CFG;
    endcase
end

always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
        state_q <= ST_CFG;
    end else begin
        state_q <= state_d;
    end
end

assign o_ctrl_state = state_q;
assign pwm_on       = (state_q == ST_NORMAL);

// ========================================
// registered outputs
// ========================================
always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
        o_dgt_ang_pwm_en <= 1'b0;
        o_dgt_ang_fsc_en <= 1'b0;
        o_io_pwm_l2h     <= 1'b0;
        o_intb_n         <= 1'b1;
    end else begin
        o_dgt_ang_pwm_en <= pwm_on;
        o_dgt_ang_fsc_en <= (state_q == ST_FAULT);
        o_io_pwm_l2h     <= pwm_on & i_ang_dgt_pwm_wv;  // same term as the enable
        o_intb_n         <= ~i_flt_any;
    end
end

a_pwm_gated: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_io_pwm_l2h |-> o_dgt_ang_pwm_en)
    else $error("pwm pin active while pwm disabled");

endmodule

`default_nettype wire

// File: hw/hv_fault_proc.sv
`timescale 1ns/1ps
`default_nettype none

module hv_fault_proc import hv_pkg::*; #(
    parameter int DEGLITCH_CYC = 4
) (
    input  logic               i_clk,
    input  logic               i_arst_n,
    input  logic               i_hv_vcc_uv,
    input  logic               i_hv_vcc_ov,
    input  logic               i_hv_ot,
    input  logic               i_hv_oc,
    input  logic               i_hv_desat_flt,
    input  logic               i_hv_scp_flt,
    output logic [NUM_FLT-1:0] o_flt_vec
);

localparam int               CNT_W   = $clog2(DEGLITCH_CYC + 1);
localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(DEGLITCH_CYC);

logic [NUM_FLT-1:0] flt_raw;
logic [NUM_FLT-1:0] flt_meta;
logic [NUM_FLT-1:0] flt_sync;

assign flt_raw = {i_hv_scp_flt, i_hv_desat_flt, i_hv_oc,
                  i_hv_ot, i_hv_vcc_ov, i_hv_vcc_uv};   // uv in bit 0

always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
        flt_meta <= '0;
        flt_sync <= '0;
    end else begin
        flt_meta <= flt_raw;
        flt_sync <= flt_meta;
    end
end

for (genvar i = 0; i < NUM_FLT; i++) begin : g_flt
    logic [CNT_W-1:0] cnt;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            cnt <= '0;
        end else if (!flt_sync[i]) begin
            cnt <= '0;              // any low sample restarts the filter
        end else if (cnt != CNT_MAX) begin
            cnt <= cnt + 1'b1;
        end
    end

    assign o_flt_vec[i] = flt_sync[i] & (cnt == CNT_MAX);
end

endmodule

`default_nettype wire

// File: hw/hv_pkg.sv
`default_nettype none

package hv_pkg;

// ========================================
// widths
// ========================================
localparam int REG_AW  = 7;
localparam int REG_DW  = 8;
localparam int FRAME_W = 16;    // {wr, addr[6:0], data[7:0]}
localparam int NUM_FLT = 6;

// ========================================
// register map
// ========================================
localparam logic [REG_AW-1:0] ADDR_MODE      = 7'h00;
localparam logic [REG_AW-1:0] ADDR_DESAT_SEL = 7'h10;
localparam logic [REG_AW-1:0] ADDR_OC_SEL    = 7'h11;
localparam logic [REG_AW-1:0] ADDR_DRV_DELAY = 7'h12;
localparam logic [REG_AW-1:0] ADDR_STATUS    = 7'h20;
localparam logic [REG_AW-1:0] ADDR_STATE     = 7'h21;   // read only

// status bits, bit 1 reads 0
localparam int ST_SPI_ERR = 0;
localparam int ST_UV      = 2;
localparam int ST_OV      = 3;
localparam int ST_OT      = 4;
localparam int ST_OC      = 5;
localparam int ST_DESAT   = 6;
localparam int ST_SCP     = 7;

typedef enum logic [1:0] {
    ST_CFG    = 2'd0,
    ST_NORMAL = 2'd1,
    ST_FAULT  = 2'd2
} ctrl_state_e;

endpackage

`default_nettype wire

// File: hw/hv_reg_slv.sv
`timescale 1ns/1ps
`default_nettype none

module hv_reg_slv import hv_pkg::*; (
    input  logic               i_clk,
    input  logic               i_arst_n,
    input  logic               i_rac_req,
    input  logic               i_rac_wr,
    input  logic [REG_AW-1:0]  i_rac_addr,
    input  logic [REG_DW-1:0]  i_rac_wdata,
    input  logic               i_spi_frame_err,
    input  logic [NUM_FLT-1:0] i_flt_vec,
    input  ctrl_state_e        i_ctrl_state,
    output logic               o_rac_ack,
    output logic [REG_DW-1:0]  o_rac_rdata,
    output logic               o_normal_en,
    output logic               o_flt_any,
    output logic [REG_DW-1:0]  o_reg_desat_sel,
    output logic [REG_DW-1:0]  o_reg_oc_sel,
    output logic [REG_DW-1:0]  o_reg_drive_delay
);

logic [REG_DW-1:0] mode_q;
logic [REG_DW-1:0] status_q;
logic [REG_DW-1:0] status_set;
logic [REG_DW-1:0] status_clr;
logic [REG_DW-1:0] rd_mux;
logic              acc_stb;
logic              wr_stb;
logic              cfg_open;

assign acc_stb  = i_rac_req & ~o_rac_ack;   // first cycle of a request
assign wr_stb   = acc_stb & i_rac_wr;
assign cfg_open = (i_ctrl_state == ST_CFG);

always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
        o_rac_ack <= 1'b0;
    end else begin
        o_rac_ack <= i_rac_req;
    end
end

// ========================================
// mode and driver config
// ========================================
always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
        mode_q            <= '0;
        o_reg_desat_sel   <= '0;
        o_reg_oc_sel      <= '0;
        o_reg_drive_delay <= '0;
    end else if (wr_stb) begin
        case (i_rac_addr)
            ADDR_MODE:      mode_q <= i_rac_wdata;
            ADDR_DESAT_SEL: if (cfg_open) o_reg_desat_sel <= i_rac_wdata;
            ADDR_OC_SEL:    if (cfg_open) o_reg_oc_sel <= i_rac_wdata;
            ADDR_DRV_DELAY: if (cfg_open) o_reg_drive_delay <= i_rac_wdata;
            default: ;
        endcase
    end
end

// ========================================
// status, write 1 to clear
// ========================================
always_comb begin
    status_set             = '0;
    status_set[ST_SPI_ERR] = i_spi_frame_err;
    status_set[ST_UV]      = i_flt_vec[0];
    status_set[ST_OV]      = i_flt_vec[1];
    status_set[ST_OT]      = i_flt_vec[2];
    status_set[ST_OC]      = i_flt_vec[3];
    status_set[ST_DESAT]   = i_flt_vec[4];
    status_set[ST_SCP]     = i_flt_vec[5];
    status_clr = (wr_stb && i_rac_addr == ADDR_STATUS) ? i_rac_wdata : '0;
end

always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
        status_q <= '0;
    end else begin
        status_q <= (status_q & ~status_clr) | status_set;  // set wins
    end
end

always_comb begin
    case (i_rac_addr)
        ADDR_MODE:      rd_mux = mode_q;
        ADDR_DESAT_SEL: rd_mux = o_reg_desat_sel;
        ADDR_OC_SEL:    rd_mux = o_reg_oc_sel;
        ADDR_DRV_DELAY: rd_mux = o_reg_drive_delay;
        ADDR_STATUS:    rd_mux = status_q;
        ADDR_STATE:     rd_mux = REG_DW'(i_ctrl_state);
        default:        rd_mux = '0;
    endcase
end

always_ff @(posedge i_clk) begin
    if (acc_stb) begin
        o_rac_rdata <= rd_mux;
    end
end

assign o_normal_en = mode_q[0];
assign o_flt_any   = |status_q;

a_ack_follows_req: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    !$past(i_rac_req) |-> !o_rac_ack)
    else $error("rac_ack high without a request");

endmodule

`default_nettype wire

// File: hw/spi_slv.sv
`timescale 1ns/1ps
`default_nettype none

module spi_slv import hv_pkg::*; (
    input  logic              i_clk,
    input  logic              i_arst_n,
    input  logic              i_spi_sclk,
    input  logic              i_spi_csb,
    input  logic              i_spi_mosi,
    output logic              o_spi_miso,
    output logic              o_rac_req,
    output logic              o_rac_wr,
    output logic [REG_AW-1:0] o_rac_addr,
    output logic [REG_DW-1:0] o_rac_wdata,
    input  logic              i_rac_ack,
    input  logic [REG_DW-1:0] i_rac_rdata,
    output logic              o_spi_frame_err
);

localparam int CNT_W = $clog2(FRAME_W) + 1;

logic [2:0]         sclk_r;     // [1] synced, [2] one cycle older
logic [2:0]         csb_r;
logic [2:0]         mosi_r;
logic               sclk_rise;
logic               sclk_fall;
logic               csb_rise;
logic               csb_fall;
logic               frame_act;
logic               frame_ok;
logic [CNT_W-1:0]   bit_cnt;
logic [FRAME_W-1:0] rx_sh;
logic [FRAME_W-1:0] resp_q;
logic [FRAME_W-1:0] tx_sh;

// ========================================
// pin sync, registered edge pulses
// ========================================
always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
        sclk_r    <= '0;
        csb_r     <= '1;            // idle high
        mosi_r    <= '0;
        sclk_rise <= 1'b0;
        sclk_fall <= 1'b0;
        csb_rise  <= 1'b0;
        csb_fall  <= 1'b0;
    end else begin
        sclk_r    <= {sclk_r[1:0], i_spi_sclk};
        csb_r     <= {csb_r[1:0], i_spi_csb};
        mosi_r    <= {mosi_r[1:0], i_spi_mosi};
        sclk_rise <= sclk_r[1] & ~sclk_r[2];
        sclk_fall <= ~sclk_r[1] & sclk_r[2];
        csb_rise  <= csb_r[1] & ~csb_r[2];
        csb_fall  <= ~csb_r[1] & csb_r[2];
    end
end

assign frame_act = ~csb_r[2];       // lines up with the edge pulses
assign frame_ok  = (bit_cnt == CNT_W'(FRAME_W));

always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
        bit_cnt <= '0;
    end else if (csb_fall) begin
        bit_cnt <= '0;
    end else if (sclk_rise && frame_act && !(&bit_cnt)) begin
        bit_cnt <= bit_cnt + 1'b1;  // saturates on long frames
    end
end

always_ff @(posedge i_clk) begin
    if (sclk_rise && frame_act) begin
        rx_sh <= {rx_sh[FRAME_W-2:0], mosi_r[2]};
    end
    if (csb_rise && frame_ok) begin
        o_rac_wr    <= rx_sh[FRAME_W-1];
        o_rac_addr  <= rx_sh[FRAME_W-2 -: REG_AW];
        o_rac_wdata <= rx_sh[REG_DW-1:0];
    end
end

// ========================================
// req/ack initiator
// ========================================
always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
        o_rac_req       <= 1'b0;
        o_spi_frame_err <= 1'b0;
    end else begin
        o_spi_frame_err <= csb_rise & ~frame_ok;
        if (csb_rise && frame_ok) begin
            o_rac_req <= 1'b1;
        end else if (i_rac_ack) begin
            o_rac_req <= 1'b0;
        end
    end
end

// response of the last good frame, replayed in the next one
always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
        resp_q <= '0;
        tx_sh  <= '0;
    end else begin
        if (o_rac_req && i_rac_ack) begin
            resp_q <= {o_rac_wr, o_rac_addr, o_rac_wr ? o_rac_wdata : i_rac_rdata};
        end
        if (csb_fall) begin
            tx_sh <= resp_q;
        end else if (sclk_fall && frame_act) begin
            tx_sh <= {tx_sh[FRAME_W-2:0], 1'b0};
        end
    end
end

assign o_spi_miso = tx_sh[FRAME_W-1];   // msb first

a_req_held: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    $fell(o_rac_req) |-> $past(i_rac_ack))
    else $error("rac_req dropped before ack");

endmodule

`default_nettype wire

// File: sources.f
+incdir+testbench
hw/hv_pkg.sv
hw/spi_slv.sv
hw/hv_fault_proc.sv
hw/hv_reg_slv.sv
hw/hv_ctrl_fsm.sv
hw/hv_core.sv
testbench/tb_hv_core.sv

// File: testbench/tb_spi_tasks.svh
`ifndef TB_SPI_TASKS_SVH
`define TB_SPI_TASKS_SVH

// mode 0 frame, tx[nbits-1:0] goes out msb first
task automatic spi_frame(input int nbits, input logic [FRAME_W-1:0] tx,
                         output logic [FRAME_W-1:0] rx);
    int i;
    rx = '0;
    @(posedge i_clk);
    i_spi_csb <= 1'b0;
    repeat (SCLK_HALF) @(posedge i_clk);
    for (i = nbits - 1; i >= 0; i--) begin
        i_spi_mosi <= tx[i];
        repeat (SCLK_HALF) @(posedge i_clk);
        @(negedge i_clk);
        rx = {rx[FRAME_W-2:0], o_spi_miso};     // miso settled since last fall
        @(posedge i_clk);
        i_spi_sclk <= 1'b1;
        repeat (SCLK_HALF) @(posedge i_clk);
        i_spi_sclk <= 1'b0;
    end
    repeat (SCLK_HALF) @(posedge i_clk);
    i_spi_csb  <= 1'b1;
    i_spi_mosi <= 1'b0;
    repeat (FRAME_GAP) @(posedge i_clk);
endtask

task automatic reg_write(input logic [REG_AW-1:0] addr, input logic [REG_DW-1:0] data);
    logic [FRAME_W-1:0] rx;
    spi_frame(FRAME_W, {1'b1, addr, data}, rx);
    prev_resp = rx;
endtask

// read frame, then a spare frame that shifts the answer out
task automatic reg_read(input logic [REG_AW-1:0] addr, output logic [REG_DW-1:0] data);
    logic [FRAME_W-1:0] rx;
    spi_frame(FRAME_W, {1'b0, addr, 8'h00}, rx);
    prev_resp = rx;
    spi_frame(FRAME_W, {1'b0, ADDR_SPARE, 8'h00}, rx);
    check_value("o_spi_miso header", 16'(rx[FRAME_W-1:REG_DW]), 16'({1'b0, addr}));
    data = rx[REG_DW-1:0];
endtask

task automatic wait_for_pin(input int sel, input logic val, input int max_cyc);
    int n;
    n = 0;
    @(negedge i_clk);
    while (pin_value(sel) !== val && n < max_cyc) begin
        @(negedge i_clk);
        n++;
    end
    if (pin_value(sel) !== val) begin
        $display("timeout, %s did not go to %0d within %0d cycles",
                 pin_name(sel), val, max_cyc);
        err_cnt++;
    end
endtask

`endif

// File: testbench/tb_hv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_hv_core import hv_pkg::*; ();

localparam int                DEGLITCH_CYC = 4;
localparam int                SCLK_HALF    = 5;
localparam int                FRAME_GAP    = 20;
localparam logic [REG_AW-1:0] ADDR_SPARE   = 7'h7F;    // unmapped, reads 0
localparam int                PIN_INTB     = 0;
localparam int                PIN_PWM_EN   = 1;
localparam int                PIN_FSC_EN   = 2;

logic              i_clk;
logic              i_arst_n;
logic              i_spi_sclk;
logic              i_spi_csb;
logic              i_spi_mosi;
logic              i_hv_vcc_uv;
logic              i_hv_vcc_ov;
logic              i_hv_ot;
logic              i_hv_oc;
logic              i_hv_desat_flt;
logic              i_hv_scp_flt;
logic              i_ang_dgt_pwm_wv;
logic              o_spi_miso;
logic              o_dgt_ang_pwm_en;
logic              o_dgt_ang_fsc_en;
logic              o_io_pwm_l2h;
logic              o_intb_n;
logic [REG_DW-1:0] o_reg_desat_sel;
logic [REG_DW-1:0] o_reg_oc_sel;
logic [REG_DW-1:0] o_reg_drive_delay;

int                 err_cnt;
int                 test_err;
int                 tests_run;
int                 tests_failed;
integer             seed;
logic [FRAME_W-1:0] prev_resp;  // miso seen during the last frame

hv_core #(
    .DEGLITCH_CYC (DEGLITCH_CYC)
) uut (
    .i_clk             (i_clk),
    .i_arst_n          (i_arst_n),
    .i_spi_sclk        (i_spi_sclk),
    .i_spi_csb         (i_spi_csb),
    .i_spi_mosi        (i_spi_mosi),
    .o_spi_miso        (o_spi_miso),
    .i_hv_vcc_uv       (i_hv_vcc_uv),
    .i_hv_vcc_ov       (i_hv_vcc_ov),
    .i_hv_ot           (i_hv_ot),
    .i_hv_oc           (i_hv_oc),
    .i_hv_desat_flt    (i_hv_desat_flt),
    .i_hv_scp_flt      (i_hv_scp_flt),
    .i_ang_dgt_pwm_wv  (i_ang_dgt_pwm_wv),
    .o_dgt_ang_pwm_en  (o_dgt_ang_pwm_en),
    .o_dgt_ang_fsc_en  (o_dgt_ang_fsc_en),
    .o_io_pwm_l2h      (o_io_pwm_l2h),
    .o_intb_n          (o_intb_n),
    .o_reg_desat_sel   (o_reg_desat_sel),
    .o_reg_oc_sel      (o_reg_oc_sel),
    .o_reg_drive_delay (o_reg_drive_delay)
);

initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
end

`include "tb_spi_tasks.svh"

task automatic check_value(input string name, input logic [FRAME_W-1:0] got,
                           input logic [FRAME_W-1:0] exp);
    a_value: assert (got === exp)
        else begin
            $display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
            err_cnt++;
        end
endtask

function automatic logic pin_value(input int sel);
    case (sel)
        PIN_INTB:   return o_intb_n;
        PIN_PWM_EN: return o_dgt_ang_pwm_en;
        default:    return o_dgt_ang_fsc_en;
    endcase
endfunction

function automatic string pin_name(input int sel);
    case (sel)
        PIN_INTB:   return "o_intb_n";
        PIN_PWM_EN: return "o_dgt_ang_pwm_en";
        default:    return "o_dgt_ang_fsc_en";
    endcase
endfunction

task automatic finish_test(input string name);
    int n;
    n = err_cnt - test_err;
    tests_run++;
    if (n == 0) begin
        $display("test %s ok", name);
    end else begin
        $display("test %s FAILED with %0d errors", name, n);
        tests_failed++;
    end
    test_err = err_cnt;
endtask

// ========================================
// always-on checks
// ========================================
a_enables_excl: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    !(o_dgt_ang_fsc_en && o_dgt_ang_pwm_en))
    else begin
        $display("ERROR o_dgt_ang_fsc_en 0x%0h o_dgt_ang_pwm_en 0x%0h both high",
                 o_dgt_ang_fsc_en, o_dgt_ang_pwm_en);
        err_cnt++;
    end

a_pin_off: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    !o_dgt_ang_pwm_en |-> !o_io_pwm_l2h)
    else begin
        $display("ERROR o_io_pwm_l2h 0x%0h with o_dgt_ang_pwm_en 0x%0h",
                 o_io_pwm_l2h, o_dgt_ang_pwm_en);
        err_cnt++;
    end

// ========================================
// stimulus
// ========================================
initial begin
    logic [REG_DW-1:0]  rd;
    logic [REG_DW-1:0]  wr_val [3];
    logic [REG_AW-1:0]  cfg_addr [3];
    logic [FRAME_W-1:0] rx;
    logic [FRAME_W-1:0] bad;
    logic               wave;
    int                 rnd;
    int                 i;

    seed         = 25;
    err_cnt      = 0;
    test_err     = 0;
    tests_run    = 0;
    tests_failed = 0;
    prev_resp    = '0;
    wave         = 1'b0;
    cfg_addr[0]  = ADDR_DESAT_SEL;
    cfg_addr[1]  = ADDR_OC_SEL;
    cfg_addr[2]  = ADDR_DRV_DELAY;

    i_arst_n         <= 1'b0;
    i_spi_sclk       <= 1'b0;
    i_spi_csb        <= 1'b1;
    i_spi_mosi       <= 1'b0;
    i_hv_vcc_uv      <= 1'b0;
    i_hv_vcc_ov      <= 1'b0;
    i_hv_ot          <= 1'b0;
    i_hv_oc          <= 1'b0;
    i_hv_desat_flt   <= 1'b0;
    i_hv_scp_flt     <= 1'b0;
    i_ang_dgt_pwm_wv <= 1'b0;
    repeat (8) @(posedge i_clk);
    i_arst_n <= 1'b1;
    repeat (2) @(posedge i_clk);

    // reset values
    @(negedge i_clk);
    check_value("o_dgt_ang_pwm_en", 16'(o_dgt_ang_pwm_en), 16'h0);
    check_value("o_dgt_ang_fsc_en", 16'(o_dgt_ang_fsc_en), 16'h0);
    check_value("o_io_pwm_l2h", 16'(o_io_pwm_l2h), 16'h0);
    check_value("o_intb_n", 16'(o_intb_n), 16'h1);
    check_value("o_reg_desat_sel", 16'(o_reg_desat_sel), 16'h0);
    check_value("o_reg_oc_sel", 16'(o_reg_oc_sel), 16'h0);
    check_value("o_reg_drive_delay", 16'(o_reg_drive_delay), 16'h0);
    reg_read(ADDR_MODE, rd);
    check_value("o_spi_miso after reset", prev_resp, 16'h0);
    check_value("mode", 16'(rd), 16'h0);
    reg_read(ADDR_STATE, rd);
    check_value("state", 16'(rd), 16'(ST_CFG));
    finish_test("reset");

    // config registers in CFG
    for (i = 0; i < 3; i++) begin
        rnd       = $random(seed);
        wr_val[i] = rnd[REG_DW-1:0];
        reg_write(cfg_addr[i], wr_val[i]);
        reg_read(cfg_addr[i], rd);
        check_value("o_spi_miso write resp", prev_resp, {1'b1, cfg_addr[i], wr_val[i]});
        check_value("cfg readback", 16'(rd), 16'(wr_val[i]));
    end
    @(negedge i_clk);
    check_value("o_reg_desat_sel", 16'(o_reg_desat_sel), 16'(wr_val[0]));
    check_value("o_reg_oc_sel", 16'(o_reg_oc_sel), 16'(wr_val[1]));
    check_value("o_reg_drive_delay", 16'(o_reg_drive_delay), 16'(wr_val[2]));
    reg_read(7'h05, rd);
    check_value("unmapped readback", 16'(rd), 16'h0);
    finish_test("config_access");

    // short glitch is filtered, long pulse latches
    @(posedge i_clk);
    i_hv_vcc_uv <= 1'b1;
    repeat (2) @(posedge i_clk);
    i_hv_vcc_uv <= 1'b0;
    repeat (FRAME_GAP) @(posedge i_clk);
    reg_read(ADDR_STATUS, rd);
    check_value("status after glitch", 16'(rd), 16'h0);
    i_hv_vcc_uv <= 1'b1;
    repeat (20) @(posedge i_clk);
    i_hv_vcc_uv <= 1'b0;
    wait_for_pin(PIN_INTB, 1'b0, 10);
    reg_read(ADDR_STATUS, rd);
    check_value("status uv", 16'(rd), 16'(1 << ST_UV));
    reg_write(ADDR_STATUS, 8'(1 << ST_UV));
    wait_for_pin(PIN_INTB, 1'b1, 20);
    reg_read(ADDR_STATUS, rd);
    check_value("status cleared", 16'(rd), 16'h0);
    finish_test("fault_filter");

    // NORMAL
    reg_write(ADDR_MODE, 8'h01);
    wait_for_pin(PIN_PWM_EN, 1'b1, 20);
    reg_read(ADDR_STATE, rd);
    check_value("state", 16'(rd), 16'(ST_NORMAL));
    for (i = 0; i < 6; i++) begin
        wave = ~wave;
        @(posedge i_clk);
        i_ang_dgt_pwm_wv <= wave;
        @(posedge i_clk);
        @(negedge i_clk);
        check_value("o_io_pwm_l2h", 16'(o_io_pwm_l2h), 16'(wave));
    end
    reg_write(ADDR_OC_SEL, ~wr_val[1]);    // locked outside CFG
    reg_read(ADDR_OC_SEL, rd);
    check_value("locked readback", 16'(rd), 16'(wr_val[1]));
    @(negedge i_clk);
    check_value("o_reg_oc_sel", 16'(o_reg_oc_sel), 16'(wr_val[1]));
    finish_test("normal_op");

    // OC shutdown
    wave = 1'b1;
    @(posedge i_clk);
    i_ang_dgt_pwm_wv <= wave;
    @(posedge i_clk);
    @(negedge i_clk);
    check_value("o_io_pwm_l2h", 16'(o_io_pwm_l2h), 16'h1);
    @(posedge i_clk);
    i_hv_oc <= 1'b1;
    wait_for_pin(PIN_FSC_EN, 1'b1, 40);
    check_value("o_dgt_ang_pwm_en", 16'(o_dgt_ang_pwm_en), 16'h0);
    check_value("o_io_pwm_l2h", 16'(o_io_pwm_l2h), 16'h0);
    @(posedge i_clk);
    i_hv_oc <= 1'b0;
    reg_read(ADDR_STATE, rd);
    check_value("state", 16'(rd), 16'(ST_FAULT));
    reg_write(ADDR_MODE, 8'h00);
    reg_write(ADDR_STATUS, 8'(1 << ST_OC));
    wait_for_pin(PIN_FSC_EN, 1'b0, 20);
    reg_read(ADDR_STATE, rd);
    check_value("state", 16'(rd), 16'(ST_CFG));
    i_ang_dgt_pwm_wv <= 1'b0;
    finish_test("fault_shutdown");

    // 12 bit frame
    bad = {1'b1, ADDR_DESAT_SEL, ~wr_val[0]};
    spi_frame(12, bad >> 4, rx);
    reg_read(ADDR_STATUS, rd);
    check_value("o_spi_miso after bad frame", prev_resp, {1'b0, ADDR_SPARE, 8'h00});
    check_value("status spi err", 16'(rd), 16'(1 << ST_SPI_ERR));
    reg_read(ADDR_DESAT_SEL, rd);
    check_value("desat readback", 16'(rd), 16'(wr_val[0]));
    @(negedge i_clk);
    check_value("o_reg_desat_sel", 16'(o_reg_desat_sel), 16'(wr_val[0]));
    reg_write(ADDR_STATUS, 8'(1 << ST_SPI_ERR));
    wait_for_pin(PIN_INTB, 1'b1, 20);
    finish_test("frame_error");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
        $display("All tests passed!");
    end else begin
        $display("Test failures found");
    end
    $finish;
end

endmodule

`default_nettype wire
